// File: tmr_rf.f
+incdir+include
src/tmr_rf_pkg.sv
src/replica_rf.sv
src/majority_vote.sv
src/scrub_ctrl.sv
src/tmr_rf_top.sv
tests/tmr_rf_tb.sv

// File: tests/tmr_rf_tb.sv
//////////////////////////////////////////////////
// directed testbench for the tmr register file.
// golden model, fault injection and scrub checks.
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tmr_rf_defs.svh"

module tmr_rf_tb;

   localparam int TIMEOUT_CYCLES = 2000;                       // tests take about 200 cycles.

   logic                    s_c_i;                             // core clock.
   logic                    reset_i;                           // sync reset.
   tmr_rf_pkg::wr_req_t     wr;                                // external write strobe.
   tmr_rf_pkg::inj_req_t    inj;                               // fault injection strobe.
   logic [`TMR_AW-1:0]      raddr [`TMR_RP];                   // read addresses.
   logic [`TMR_W-1:0]       rdata [`TMR_RP];                   // voted read data.
   tmr_rf_pkg::vote_rpt_t   rpt   [`TMR_RP];                   // per port vote reports.
   tmr_rf_pkg::scrub_rpt_t  scrub;                             // scrubber report.

   logic [`TMR_W-1:0]       golden [`TMR_N];                   // mirrors external writes.
   logic [`TMR_AW-1:0]      ptr_model;                         // expected sweep pointer.
   int                      fix_count;                         // repair pulses seen.
   tmr_rf_pkg::scrub_rpt_t  last_fix;                          // report of the latest repair.
   int                      fix_base;                          // fix_count at test start.
   int                      errors;
   int                      checks;
   int                      cycle_cnt;
   logic [`TMR_AW-1:0]      upset_addr;                        // shared by single upset tests.
   logic [1:0]              upset_copy;

   tmr_rf_top DUT (
      .s_c_i   (s_c_i),
      .reset_i (reset_i),
      .wr_i    (wr),
      .inj_i   (inj),
      .raddr_i (raddr),
      .rdata_o (rdata),
      .rpt_o   (rpt),
      .scrub_o (scrub)
   );

   //////////////////////////////////////////////////
   // clock, timeout and monitors
   //////////////////////////////////////////////////

   initial begin
      s_c_i = 1'b0;
      forever #20 s_c_i = ~s_c_i;                              // 40 ns period.
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge s_c_i);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
   end

   // sweep advances once per cycle, holds under an external write.
   always @(posedge s_c_i) begin
      if (reset_i) begin
         ptr_model <= '0;
      end else if (!wr.valid) begin
         ptr_model <= `TMR_AW'((ptr_model + 1) % `TMR_N);      // wrap at depth.
      end
   end

   always @(negedge s_c_i) begin
      if (!reset_i && scrub.fix) begin
         fix_count = fix_count + 1;                            // mid cycle, outputs are stable.
         last_fix  = scrub;
      end
   end

   //////////////////////////////////////////////////
   // helpers and compare tasks
   //////////////////////////////////////////////////

   task automatic next_cycle;
      @(posedge s_c_i);
      #2;                                                      // drive after the edge.
   endtask

   task automatic sample;
      @(negedge s_c_i);
   endtask

   task automatic read_both(input logic [`TMR_AW-1:0] addr);
      raddr[0] = addr;
      raddr[1] = addr;
   endtask

   function automatic tmr_rf_pkg::vote_rpt_t make_vote(input logic c, input logic [1:0] r,
                                                      input logic m);
      tmr_rf_pkg::vote_rpt_t v;
      v.corrected = c;
      v.replica   = r;
      v.multi     = m;
      return v;
   endfunction

   task automatic check_word(input string name, input logic [`TMR_W-1:0] got,
                             input logic [`TMR_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_vote(input string name, input tmr_rf_pkg::vote_rpt_t got,
                             input tmr_rf_pkg::vote_rpt_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_scrub(input string name, input tmr_rf_pkg::scrub_rpt_t got,
                              input tmr_rf_pkg::scrub_rpt_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_fix_count(input int expected);
      checks++;
      if ((fix_count - fix_base) != expected) begin
         errors++;
         $display("ERROR scrub_o.fix count: got %h expected %h", fix_count - fix_base, expected);
      end
   endtask

   // both ports read the same word.
   task automatic expect_read(input logic [`TMR_W-1:0] exp_word,
                              input tmr_rf_pkg::vote_rpt_t exp_vote);
      for (int p = 0; p < `TMR_RP; p++) begin
         check_word($sformatf("rdata_o[%0d]", p), rdata[p], exp_word);
         check_vote($sformatf("rpt_o[%0d]", p), rpt[p], exp_vote);
      end
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////

   task automatic test_reset_and_writes;
      logic [`TMR_AW-1:0] a;
      logic [`TMR_W-1:0]  d;
      for (int i = 0; i < `TMR_N; i++) begin
         raddr[0] = `TMR_AW'(i);
         raddr[1] = `TMR_AW'(`TMR_N - 1 - i);                  // other port walks down.
         sample;
         expect_read('0, make_vote(1'b0, 2'd0, 1'b0));
         next_cycle;
      end
      for (int n = 0; n < 16; n++) begin
         a = `TMR_AW'($urandom % `TMR_N);
         d = $urandom;
         wr.valid = 1'b1;
         wr.addr  = a;
         wr.data  = d;
         golden[a] = d;
         next_cycle;
         wr.valid = 1'b0;
         raddr[0] = a;                                         // lands at the last edge.
         raddr[1] = `TMR_AW'($urandom % `TMR_N);
         sample;
         check_word("rdata_o[0]", rdata[0], golden[a]);
         check_vote("rpt_o[0]", rpt[0], make_vote(1'b0, 2'd0, 1'b0));
         check_word("rdata_o[1]", rdata[1], golden[raddr[1]]);
         check_vote("rpt_o[1]", rpt[1], make_vote(1'b0, 2'd0, 1'b0));
         next_cycle;
      end
   endtask

   task automatic test_single_upset;
      fix_base   = fix_count;
      upset_copy = 2'($urandom % 3);
      upset_addr = `TMR_AW'((ptr_model + 8) % `TMR_N);         // well ahead of the sweep.
      inj.valid   = 1'b1;
      inj.replica = upset_copy;
      inj.addr    = upset_addr;
      inj.mask    = $urandom | 32'h1;                          // at least one flipped bit.
      next_cycle;
      inj = '0;
      read_both(upset_addr);
      sample;
      expect_read(golden[upset_addr], make_vote(1'b1, upset_copy, 1'b0));
      next_cycle;
      if (fix_count != fix_base) begin
         errors++;
         $display("scrubber issued a repair before it reached the upset address");
      end
   endtask

   task automatic test_scrub_repair;
      tmr_rf_pkg::scrub_rpt_t exp;
      exp.fix   = 1'b1;
      exp.addr  = upset_addr;
      exp.multi = 1'b0;
      repeat (`TMR_N) next_cycle;                              // one full sweep, no writes.
      check_fix_count(1);
      check_scrub("scrub_o", last_fix, exp);
      read_both(upset_addr);
      sample;
      expect_read(golden[upset_addr], make_vote(1'b0, 2'd0, 1'b0));
      next_cycle;
   endtask

   task automatic test_double_upset;
      logic [`TMR_AW-1:0]     a;
      logic [`TMR_W-1:0]      m0;
      logic [`TMR_W-1:0]      m1;
      tmr_rf_pkg::scrub_rpt_t exp;
      fix_base = fix_count;
      a  = `TMR_AW'((ptr_model + 8) % `TMR_N);
      m0 = ($urandom & 32'h0000_ffff) | 32'h0000_0001;         // low half only.
      m1 = ($urandom & 32'hffff_0000) | 32'h0001_0000;         // high half, no overlap.
      inj.valid   = 1'b1;
      inj.replica = 2'd0;
      inj.addr    = a;
      inj.mask    = m0;
      next_cycle;
      inj.replica = 2'd1;
      inj.mask    = m1;
      next_cycle;
      inj = '0;
      read_both(a);
      sample;
      expect_read(golden[a], make_vote(1'b1, 2'd3, 1'b1));    // bitwise vote still recovers.
      next_cycle;
      repeat (`TMR_N) next_cycle;
      exp.fix   = 1'b1;
      exp.addr  = a;
      exp.multi = 1'b1;
      check_fix_count(1);
      check_scrub("scrub_o", last_fix, exp);
      sample;
      expect_read(golden[a], make_vote(1'b0, 2'd0, 1'b0));
      next_cycle;
   endtask

   task automatic test_write_over_upset;
      logic [`TMR_AW-1:0] a;
      logic [`TMR_W-1:0]  d;
      fix_base = fix_count;
      a = `TMR_AW'((ptr_model + 1) % `TMR_N);                  // sweep reaches it next cycle.
      inj.valid   = 1'b1;
      inj.replica = 2'($urandom % 3);
      inj.addr    = a;
      inj.mask    = $urandom | 32'h1;
      next_cycle;
      inj = '0;
      read_both(a);
      for (int n = 0; n < 6; n++) begin
         d = $urandom;
         wr.valid = 1'b1;
         wr.addr  = a;
         wr.data  = d;
         if (n > 0) begin
            sample;                                            // previous write has landed.
            expect_read(golden[a], make_vote(1'b0, 2'd0, 1'b0));
         end
         golden[a] = d;
         next_cycle;
      end
      wr.valid = 1'b0;
      sample;
      expect_read(golden[a], make_vote(1'b0, 2'd0, 1'b0));
      next_cycle;
      check_fix_count(0);
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(89));
      errors    = 0;
      checks    = 0;
      fix_count = 0;
      fix_base  = 0;
      last_fix  = '0;
      reset_i   = 1'b1;
      wr        = '0;
      inj       = '0;
      raddr[0]  = '0;
      raddr[1]  = '0;
      for (int i = 0; i < `TMR_N; i++) begin
         golden[i] = '0;                                       // reset clears every copy.
      end
      repeat (4) @(posedge s_c_i);
      #2;
      reset_i = 1'b0;
      test_reset_and_writes;
      test_single_upset;
      test_scrub_repair;
      test_double_upset;
      test_write_over_upset;
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: src/tmr_rf_top.sv
//////////////////////////////////////////////////
// triple redundant register file top level.
// three copies, per port voters and a scrubber.
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tmr_rf_defs.svh"

module tmr_rf_top (
   input  logic                     s_c_i,                     // core clock.
   input  logic                     reset_i,                   // sync reset, active high.
   input  tmr_rf_pkg::wr_req_t      wr_i,                      // external write.
   input  tmr_rf_pkg::inj_req_t     inj_i,                     // fault injection.
   input  logic [`TMR_AW-1:0]       raddr_i [`TMR_RP],         // external read addresses.
   output logic [`TMR_W-1:0]        rdata_o [`TMR_RP],         // voted read data.
   output tmr_rf_pkg::vote_rpt_t    rpt_o   [`TMR_RP],         // per port vote reports.
   output tmr_rf_pkg::scrub_rpt_t   scrub_o                    // scrubber report.
);

   //////////////////////////////////////////////////
   // internal wiring
   //////////////////////////////////////////////////

   tmr_rf_pkg::wr_req_t wr_m;                                  // merged write.
   logic [`TMR_AW-1:0]  scrub_addr;                            // scrub read address.
   logic [`TMR_AW-1:0]  rf_raddr   [`TMR_RP+1];                // replica read addresses.
   logic [`TMR_W-1:0]   rf_rdata   [`TMR_COPIES][`TMR_RP+1];   // raw words per copy.
   logic [`TMR_W-1:0]   scrub_data [`TMR_COPIES];              // scrub port per copy.

   genvar p;
   genvar c;

   generate
      for (p = 0; p < `TMR_RP; p++) begin : g_raddr
         assign rf_raddr[p] = raddr_i[p];
      end
   endgenerate

   assign rf_raddr[`TMR_RP] = scrub_addr;                      // last port is the scrub port.

   //////////////////////////////////////////////////
   // replicas
   //////////////////////////////////////////////////

   generate
      for (c = 0; c < `TMR_COPIES; c++) begin : g_copy
         replica_rf #(
            .COPY_ID (c)
         ) u_replica (
            .s_c_i   (s_c_i),
            .reset_i (reset_i),
            .wr_i    (wr_m),
            .inj_i   (inj_i),
            .raddr_i (rf_raddr),
            .rdata_o (rf_rdata[c])
         );
         assign scrub_data[c] = rf_rdata[c][`TMR_RP];
      end
   endgenerate

   //////////////////////////////////////////////////
   // read voters and scrubber
   //////////////////////////////////////////////////

   generate
      for (p = 0; p < `TMR_RP; p++) begin : g_vote
         majority_vote u_vote (
            .a_i     (rf_rdata[0][p]),
            .b_i     (rf_rdata[1][p]),
            .c_i     (rf_rdata[2][p]),
            .data_o  (rdata_o[p]),
            .rpt_o   (rpt_o[p])
         );
      end
   endgenerate

   scrub_ctrl u_scrub (
      .s_c_i         (s_c_i),
      .reset_i       (reset_i),
      .wr_i          (wr_i),
      .scrub_data_i  (scrub_data),
      .scrub_addr_o  (scrub_addr),
      .wr_o          (wr_m),
      .scrub_o       (scrub_o)
   );

endmodule

// File: src/scrub_ctrl.sv
//////////////////////////////////////////////////
// background scrubber for the tmr register file.
// sweeps addresses, votes, writes back repairs.
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tmr_rf_defs.svh"

module scrub_ctrl (
   input  logic                     s_c_i,                     // core clock.
   input  logic                     reset_i,                   // sync reset, active high.
   input  tmr_rf_pkg::wr_req_t      wr_i,                      // external write.
   input  logic [`TMR_W-1:0]        scrub_data_i [`TMR_COPIES],// scrub port of each copy.
   output logic [`TMR_AW-1:0]       scrub_addr_o,              // scrub read address.
   output tmr_rf_pkg::wr_req_t      wr_o,                      // merged write to all copies.
   output tmr_rf_pkg::scrub_rpt_t   scrub_o                    // repair report.
);

   //////////////////////////////////////////////////
   // sweep pointer
   //////////////////////////////////////////////////

   logic [`TMR_AW-1:0]     ptr;                                // current scrub address.
   logic [`TMR_W-1:0]      voted;                              // voted scrub word.
   tmr_rf_pkg::vote_rpt_t  vrpt;                               // scrub port vote status.
   logic                   repair;                             // repair write this cycle.

   always_ff @(posedge s_c_i) begin
      if (reset_i) begin
         ptr <= '0;
      end else if (!wr_i.valid) begin                          // external write holds the sweep.
         if (ptr == (`TMR_N - 1)) begin
            ptr <= '0;                                         // wrap.
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   assign scrub_addr_o = ptr;

   //////////////////////////////////////////////////
   // vote and repair
   //////////////////////////////////////////////////

   majority_vote u_vote (
      .a_i     (scrub_data_i[0]),
      .b_i     (scrub_data_i[1]),
      .c_i     (scrub_data_i[2]),
      .data_o  (voted),
      .rpt_o   (vrpt)
   );

   assign repair = vrpt.corrected && !wr_i.valid;              // only in an idle write slot.

   always_comb begin
      if (wr_i.valid) begin
         wr_o = wr_i;                                          // external write wins.
      end else begin
         wr_o.valid = repair;
         wr_o.addr  = ptr;
         wr_o.data  = voted;                                   // rewrite all copies.
      end
   end

   always_comb begin
      scrub_o.fix   = repair;                                  // one cycle pulse.
      scrub_o.addr  = ptr;
      scrub_o.multi = repair && vrpt.multi;
   end

   // a write to the scrub address shows in the vote next cycle since ptr holds.
   a_ext_write_passes : assert property (
      @(posedge s_c_i) disable iff (reset_i)
      (wr_i.valid && (wr_i.addr == ptr)) |=> (voted == $past(wr_i.data))
   );

endmodule

// File: src/majority_vote.sv
//////////////////////////////////////////////////
// bitwise two of three voter.
// reports the outvoted copy per read port.
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tmr_rf_defs.svh"

module majority_vote (
   input  logic [`TMR_W-1:0]        a_i,                       // copy 0.
   input  logic [`TMR_W-1:0]        b_i,                       // copy 1.
   input  logic [`TMR_W-1:0]        c_i,                       // copy 2.
   output logic [`TMR_W-1:0]        data_o,                    // voted word.
   output tmr_rf_pkg::vote_rpt_t    rpt_o                      // disagreement report.
);

   logic [`TMR_W-1:0]   voted;                                 // per bit majority.
   logic                diff_a;                                // copy 0 differs from vote.
   logic                diff_b;                                // copy 1 differs from vote.
   logic                diff_c;                                // copy 2 differs from vote.

   assign voted  = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);    // two of three per bit.
   assign diff_a = |(a_i ^ voted);
   assign diff_b = |(b_i ^ voted);
   assign diff_c = |(c_i ^ voted);
   assign data_o = voted;

   always_comb begin
      rpt_o.corrected = diff_a | diff_b | diff_c;              // any copy off.
      rpt_o.multi     = (diff_a & diff_b) | (diff_a & diff_c) | (diff_b & diff_c);
      if (rpt_o.multi) begin
         rpt_o.replica = 2'd3;                                 // no single culprit.
      end else if (diff_a) begin
         rpt_o.replica = 2'd0;
      end else if (diff_b) begin
         rpt_o.replica = 2'd1;
      end else if (diff_c) begin
         rpt_o.replica = 2'd2;
      end else begin
         rpt_o.replica = 2'd0;                                 // all agree.
      end
   end

   // corrected needs unequal copies and multi needs three distinct copies.
   always_comb begin : chk_multi
      a_corrected_inputs : assert final (
         $isunknown({a_i, b_i, c_i}) ||
         (rpt_o.corrected == ((a_i != b_i) || (b_i != c_i)))
      );
      a_multi_corrected : assert final (
         $isunknown({a_i, b_i, c_i}) || !rpt_o.multi ||
         (rpt_o.corrected && (a_i != b_i) && (a_i != c_i) && (b_i != c_i))
      );
   end

endmodule

// File: src/replica_rf.sv
//////////////////////////////////////////////////
// single replica of the tmr register file.
// sync write, fault injection, combinational reads.
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tmr_rf_defs.svh"

module replica_rf #(
   parameter int COPY_ID = 0                                   // index matched against inj_i.replica.
) (
   input  logic                     s_c_i,                     // core clock.
   input  logic                     reset_i,                   // sync reset, active high.
   input  tmr_rf_pkg::wr_req_t      wr_i,                      // merged write from the scrubber.
   input  tmr_rf_pkg::inj_req_t     inj_i,                     // fault injection, shared by copies.
   input  logic [`TMR_AW-1:0]       raddr_i [`TMR_RP+1],       // external ports then scrub port.
   output logic [`TMR_W-1:0]        rdata_o [`TMR_RP+1]        // raw stored words.
);

   //////////////////////////////////////////////////
   // storage and decode
   //////////////////////////////////////////////////

   logic [`TMR_W-1:0]   mem [`TMR_N];                          // register array.
   logic                inj_hit;                               // injection aimed at this copy.
   logic                same_addr;                             // write and injection collide.
   logic [`TMR_W-1:0]   wr_mask;                               // mask folded into the write data.

   assign inj_hit   = inj_i.valid && (inj_i.replica == 2'(COPY_ID));  // own copy only.
   assign same_addr = wr_i.valid && (wr_i.addr == inj_i.addr);        // same word this edge.
   assign wr_mask   = (inj_hit && same_addr) ? inj_i.mask : '0;      // upset lands on new data.

   //////////////////////////////////////////////////
   // write and injection
   //////////////////////////////////////////////////

   always_ff @(posedge s_c_i) begin
      if (reset_i) begin
         for (int i = 0; i < `TMR_N; i++) begin
            mem[i] <= '0;                                      // all copies start equal.
         end
      end else begin
         if (wr_i.valid) begin
            mem[wr_i.addr] <= wr_i.data ^ wr_mask;             // write, maybe upset too.
         end
         if (inj_hit && !same_addr) begin
            mem[inj_i.addr] <= mem[inj_i.addr] ^ inj_i.mask;   // flip stored bits.
         end
      end
   end

   //////////////////////////////////////////////////
   // read ports
   //////////////////////////////////////////////////

   genvar p;
   generate
      for (p = 0; p < `TMR_RP + 1; p++) begin : g_rd
         assign rdata_o[p] = mem[raddr_i[p]];                  // same cycle read.
      end
   endgenerate

   // only copies 0 to 2 exist, replica 3 would upset nothing.
   a_inj_replica_range : assert property (
      @(posedge s_c_i) disable iff (reset_i)
      inj_i.valid |-> (inj_i.replica < 2'd3)
   );

endmodule

// File: src/tmr_rf_pkg.sv
//////////////////////////////////////////////////
// tmr register file shared types.
// request and report structs for rtl and testbench.
//////////////////////////////////////////////////

`include "tmr_rf_defs.svh"

package tmr_rf_pkg;

   //////////////////////////////////////////////////
   // requests
   //////////////////////////////////////////////////

   // single cycle write strobe, 38 bits.
   typedef struct packed {
      logic                valid;   // write this cycle.
      logic [`TMR_AW-1:0]  addr;    // target register.
      logic [`TMR_W-1:0]   data;    // new contents.
   } wr_req_t;

   // single cycle fault injection, 40 bits.
   typedef struct packed {
      logic                valid;   // inject this cycle.
      logic [1:0]          replica; // copy to upset, 0 to 2.
      logic [`TMR_AW-1:0]  addr;    // register to upset.
      logic [`TMR_W-1:0]   mask;    // bits to flip.
   } inj_req_t;

   //////////////////////////////////////////////////
   // reports
   //////////////////////////////////////////////////

   // per read port voter status.
   typedef struct packed {
      logic                corrected; // copies were not all equal.
      logic [1:0]          replica;   // outvoted copy, 3 when several.
      logic                multi;     // more than one copy disagreed.
   } vote_rpt_t;

   // scrubber repair status.
   typedef struct packed {
      logic                fix;     // repair write issued this cycle.
      logic [`TMR_AW-1:0]  addr;    // register being repaired.
      logic                multi;   // repair covered two bad copies.
   } scrub_rpt_t;

endpackage

// File: include/tmr_rf_defs.svh
//////////////////////////////////////////////////
// tmr register file sizing macros.
// word width, depth, address width, port and copy counts.
//////////////////////////////////////////////////

`ifndef TMR_RF_DEFS_SVH
`define TMR_RF_DEFS_SVH

// data word width in bits.
`define TMR_W 32

// number of registers per replica.
`define TMR_N 32

// address width, log2 of the register count.
`define TMR_AW 5

// external read ports, the scrub port comes on top.
`define TMR_RP 2

// replica count, the voter is two of three so this stays fixed.
`define TMR_COPIES 3

`endif
